// File: common/jfive_exec_pkg.sv
package jfive_exec_pkg;

    // ----------------------------------------------------------------------
    // widths
    // ----------------------------------------------------------------------

    // data path width
    localparam int XLEN = 32;

    // shift amount and register index widths
    localparam int SHAMT_BITS = 5;
    localparam int RIDX_BITS = 5;

    // shifter internals, one extra bit so that XLEN + 31 fits
    localparam int EXT_SHAMT_BITS = SHAMT_BITS + 1;
    localparam int EXT_DATA_BITS = XLEN * 3;

    // ----------------------------------------------------------------------
    // operations
    // ----------------------------------------------------------------------

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLT  = 4'd5,
        SLTU = 4'd6,
        SLL  = 4'd7,
        SRL  = 4'd8,
        SRA  = 4'd9
    } exec_op_t;

    // true for the three operations handled by the shifter
    function automatic logic is_shift_op(input exec_op_t op);
        logic hit;
        hit = (op == SLL) || (op == SRL) || (op == SRA);
        return hit;
    endfunction

endpackage

// File: rtl/jfive_alu.sv
`timescale 1ns/1ps

module jfive_alu
    import jfive_exec_pkg::*;
(
    input  logic            reset,
    input  logic            clk,
    input  logic            cke,
    input  logic            m_acceptable,

    // operation and operands, b is already muxed with the immediate
    input  exec_op_t        s_op,
    input  logic [XLEN-1:0] s_a_val,
    input  logic [XLEN-1:0] s_b_val,

    // result, two advances later
    output logic [XLEN-1:0] m_rd_val
);

    logic advance;

    assign advance = cke && m_acceptable;

    // ----------------------------------------------------------------------
    // stage 0
    // ----------------------------------------------------------------------

    exec_op_t        st0_op;
    logic [XLEN-1:0] st0_a_val;
    logic [XLEN-1:0] st0_b_val;
    logic            st0_live;

    always_ff @(posedge clk) begin
        if (advance) begin
            st0_op    <= s_op;
            st0_a_val <= s_a_val;
            st0_b_val <= s_b_val;
        end
    end

    // set once stage 0 holds something loaded after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            st0_live <= 1'b0;
        end else if (advance) begin
            st0_live <= 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // stage 1
    // ----------------------------------------------------------------------

    logic [XLEN-1:0] result;
    logic [XLEN-1:0] st1_rd_val;

    always_comb begin
        case (st0_op)
            SUB:     result = st0_a_val - st0_b_val;
            AND:     result = st0_a_val & st0_b_val;
            OR:      result = st0_a_val | st0_b_val;
            XOR:     result = st0_a_val ^ st0_b_val;
            SLT:     result = XLEN'($signed(st0_a_val) < $signed(st0_b_val));
            SLTU:    result = XLEN'(st0_a_val < st0_b_val);
            default: result = st0_a_val + st0_b_val;
        endcase
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            st1_rd_val <= result;
        end
    end

    assign m_rd_val = st1_rd_val;

    // control substitutes ADD for shifts, so none may get here
    a_no_shift_op: assert property (
        @(posedge clk) disable iff (reset)
        st0_live |-> !(st0_op inside {SLL, SRL, SRA})
    );

endmodule

// File: rtl/jfive_exec_ctl.sv
`timescale 1ns/1ps

module jfive_exec_ctl
    import jfive_exec_pkg::*;
(
    input  logic                  reset,
    input  logic                  clk,
    input  logic                  cke,
    input  logic                  m_acceptable,

    // decoded instruction from the source
    input  logic                  s_valid,
    input  logic                  s_imm_en,
    input  exec_op_t              s_op,
    input  logic [RIDX_BITS-1:0]  s_rd_idx,
    input  logic [XLEN-1:0]       s_rs2_val,
    input  logic [XLEN-1:0]       s_imm_val,

    // to the shifter
    output logic                  shift_left,
    output logic                  shift_arithmetic,
    output logic                  shift_imm_en,
    output logic [SHAMT_BITS-1:0] shift_amount,
    output logic [SHAMT_BITS-1:0] imm_amount,

    // to the alu
    output exec_op_t              alu_op,
    output logic [XLEN-1:0]       alu_b_val,

    // results back from both units
    input  logic [XLEN-1:0]       alu_rd_val,
    input  logic [XLEN-1:0]       shift_rd_val,

    // to the sink
    output logic                  m_valid,
    output logic [RIDX_BITS-1:0]  m_rd_idx,
    output logic [XLEN-1:0]       m_rd_val
);

    logic advance;
    logic sel_shift;

    assign advance = cke && m_acceptable;

    // ----------------------------------------------------------------------
    // decode
    // ----------------------------------------------------------------------

    assign sel_shift        = is_shift_op(s_op);
    assign shift_left       = (s_op == SLL);
    assign shift_arithmetic = (s_op == SRA);
    assign shift_imm_en     = s_imm_en;
    assign shift_amount     = s_rs2_val[SHAMT_BITS-1:0];
    assign imm_amount       = s_imm_val[SHAMT_BITS-1:0];

    // shifts park the alu on a harmless add
    assign alu_op    = sel_shift ? ADD : s_op;
    assign alu_b_val = s_imm_en ? s_imm_val : s_rs2_val;

    // ----------------------------------------------------------------------
    // valid, index and source pipeline
    // ----------------------------------------------------------------------

    logic                 st0_valid;
    logic                 st1_valid;
    logic [RIDX_BITS-1:0] st0_rd_idx;
    logic [RIDX_BITS-1:0] st1_rd_idx;
    logic                 st0_sel_shift;
    logic                 st1_sel_shift;

    always_ff @(posedge clk) begin
        if (reset) begin
            st0_valid <= 1'b0;
            st1_valid <= 1'b0;
        end else if (advance) begin
            st0_valid <= s_valid;
            st1_valid <= st0_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            st0_rd_idx    <= s_rd_idx;
            st0_sel_shift <= sel_shift;
            st1_rd_idx    <= st0_rd_idx;
            st1_sel_shift <= st0_sel_shift;
        end
    end

    // output select
    assign m_valid  = st1_valid;
    assign m_rd_idx = st1_rd_idx;
    assign m_rd_val = st1_sel_shift ? shift_rd_val : alu_rd_val;

    // a held item stays put until the sink takes it
    a_hold_stable: assert property (
        @(posedge clk) disable iff (reset)
        (m_valid && !advance) |=> (m_valid && $stable(m_rd_idx))
    );

endmodule

// File: rtl/jfive_exec_unit.sv
`timescale 1ns/1ps

module jfive_exec_unit
    import jfive_exec_pkg::*;
(
    input  logic                 reset,
    input  logic                 clk,
    input  logic                 cke,

    // decoded instruction in
    input  logic                 s_valid,
    input  exec_op_t             s_op,
    input  logic [RIDX_BITS-1:0] s_rd_idx,
    input  logic [XLEN-1:0]      s_rs1_val,
    input  logic [XLEN-1:0]      s_rs2_val,
    input  logic                 s_imm_en,
    input  logic [XLEN-1:0]      s_imm_val,

    // write-back out
    output logic                 m_valid,
    output logic [RIDX_BITS-1:0] m_rd_idx,
    output logic [XLEN-1:0]      m_rd_val,
    input  logic                 m_acceptable
);

    // ----------------------------------------------------------------------
    // control to units
    // ----------------------------------------------------------------------

    logic                  shift_left;
    logic                  shift_arithmetic;
    logic                  shift_imm_en;
    logic [SHAMT_BITS-1:0] shift_amount;
    logic [SHAMT_BITS-1:0] imm_amount;
    exec_op_t              alu_op;
    logic [XLEN-1:0]       alu_b_val;

    // unit results back to control
    logic [XLEN-1:0]       alu_rd_val;
    logic [XLEN-1:0]       shift_rd_val;

    jfive_exec_ctl u_ctl (
        .reset            (reset),
        .clk              (clk),
        .cke              (cke),
        .m_acceptable     (m_acceptable),
        .s_valid          (s_valid),
        .s_imm_en         (s_imm_en),
        .s_op             (s_op),
        .s_rd_idx         (s_rd_idx),
        .s_rs2_val        (s_rs2_val),
        .s_imm_val        (s_imm_val),
        .shift_left       (shift_left),
        .shift_arithmetic (shift_arithmetic),
        .shift_imm_en     (shift_imm_en),
        .shift_amount     (shift_amount),
        .imm_amount       (imm_amount),
        .alu_op           (alu_op),
        .alu_b_val        (alu_b_val),
        .alu_rd_val       (alu_rd_val),
        .shift_rd_val     (shift_rd_val),
        .m_valid          (m_valid),
        .m_rd_idx         (m_rd_idx),
        .m_rd_val         (m_rd_val)
    );

    // rs1 feeds both units directly
    jfive_alu u_alu (
        .reset        (reset),
        .clk          (clk),
        .cke          (cke),
        .m_acceptable (m_acceptable),
        .s_op         (alu_op),
        .s_a_val      (s_rs1_val),
        .s_b_val      (alu_b_val),
        .m_rd_val     (alu_rd_val)
    );

    jfive_shifter u_shifter (
        .reset        (reset),
        .clk          (clk),
        .cke          (cke),
        .m_acceptable (m_acceptable),
        .s_left       (shift_left),
        .s_arithmetic (shift_arithmetic),
        .s_imm_en     (shift_imm_en),
        .s_rs1_val    (s_rs1_val),
        .s_rs2_val    (shift_amount),
        .s_shamt      (imm_amount),
        .m_rd_val     (shift_rd_val)
    );

endmodule

// File: rtl/jfive_shifter.sv
`timescale 1ns/1ps

module jfive_shifter
    import jfive_exec_pkg::*;
(
    input  logic                  reset,
    input  logic                  clk,
    input  logic                  cke,
    input  logic                  m_acceptable,

    // operation flags and operands
    input  logic                  s_left,
    input  logic                  s_arithmetic,
    input  logic                  s_imm_en,
    input  logic [XLEN-1:0]       s_rs1_val,
    input  logic [SHAMT_BITS-1:0] s_rs2_val,
    input  logic [SHAMT_BITS-1:0] s_shamt,

    // result, two advances later
    output logic [XLEN-1:0]       m_rd_val
);

    logic advance;

    assign advance = cke && m_acceptable;

    // ----------------------------------------------------------------------
    // stage 0
    // ----------------------------------------------------------------------

    logic [SHAMT_BITS-1:0]     amount;
    logic [EXT_SHAMT_BITS-1:0] st0_shamt;
    logic [EXT_DATA_BITS-1:0]  st0_ext_val;

    assign amount = s_imm_en ? s_shamt : s_rs2_val;

    // right shifts go past the middle word, left shifts stop short of it
    always_ff @(posedge clk) begin
        if (advance) begin
            if (s_left) begin
                st0_shamt <= EXT_SHAMT_BITS'(XLEN) - EXT_SHAMT_BITS'(amount);
            end else begin
                st0_shamt <= EXT_SHAMT_BITS'(XLEN) + EXT_SHAMT_BITS'(amount);
            end

            // top word holds the fill bits, bottom word stays zero
            if (s_arithmetic) begin
                st0_ext_val <= {{XLEN{s_rs1_val[XLEN-1]}}, s_rs1_val, {XLEN{1'b0}}};
            end else begin
                st0_ext_val <= {{XLEN{1'b0}}, s_rs1_val, {XLEN{1'b0}}};
            end
        end
    end

    // ----------------------------------------------------------------------
    // stage 1
    // ----------------------------------------------------------------------

    logic [EXT_DATA_BITS-1:0] shifted;
    logic [XLEN-1:0]          st1_rd_val;

    assign shifted = st0_ext_val >> st0_shamt;

    always_ff @(posedge clk) begin
        if (advance) begin
            st1_rd_val <= shifted[XLEN-1:0];
        end
    end

    assign m_rd_val = st1_rd_val;

    // amount taken on an advance must come out known in stage 0
    a_shamt_known: assert property (
        @(posedge clk) disable iff (reset)
        advance |=> !$isunknown(st0_shamt)
    );

endmodule

// File: run.sh
#!/bin/sh
# build and run the execute unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f src.f \
    --top-module tb_exec_unit \
    -Mdir obj_dir

./obj_dir/Vtb_exec_unit > sim.log 2>&1
cat sim.log

if grep -q "Test FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "Test OK" sim.log; then
    echo "no pass message in sim.log"
    exit 1
fi
echo "simulation passed"

// File: src.f
common/jfive_exec_pkg.sv
rtl/jfive_shifter.sv
rtl/jfive_alu.sv
rtl/jfive_exec_ctl.sv
rtl/jfive_exec_unit.sv
tests/tb_exec_unit.sv

// File: tests/tb_exec_unit.sv
`timescale 1ns/1ps

module tb_exec_unit
    import jfive_exec_pkg::*;
();

    localparam int N_ALU = 100;
    localparam int N_SHIFT = 60;
    localparam int N_FLOW = 80;
    localparam int N_EXTRA = 13;
    localparam int N_ITEMS = N_ALU + N_SHIFT + N_FLOW + N_EXTRA;
    localparam int WATCHDOG_CYCLES = N_ITEMS * 8 + 200;

    logic                 reset;
    logic                 clk;
    logic                 cke;
    logic                 m_acceptable;
    logic                 s_valid;
    exec_op_t             s_op;
    logic [RIDX_BITS-1:0] s_rd_idx;
    logic [XLEN-1:0]      s_rs1_val;
    logic [XLEN-1:0]      s_rs2_val;
    logic                 s_imm_en;
    logic [XLEN-1:0]      s_imm_val;
    logic                 m_valid;
    logic [RIDX_BITS-1:0] m_rd_idx;
    logic [XLEN-1:0]      m_rd_val;

    int          seed = 12;
    logic        flow_random = 1'b0;
    int unsigned bp_pct = 0;
    int unsigned cke_low_pct = 0;
    string       item_name = "idle";

    // scoreboard holds one entry per accepted item
    logic [XLEN-1:0]      exp_val_q[$];
    logic [RIDX_BITS-1:0] exp_idx_q[$];
    int                   exp_stamp_q[$];
    string                exp_name_q[$];

    logic [XLEN-1:0]      front_val;
    logic [RIDX_BITS-1:0] front_idx;
    int                   front_stamp;
    string                front_name;
    logic [XLEN-1:0]      b_val;

    int adv_count = 0;
    int taken_cnt = 0;
    int edges_seen = 0;
    int checks = 0;
    int data_errors = 0;
    int hold_errors = 0;
    int reset_errors = 0;
    int leftover_errors = 0;
    int total_errors = 0;

    exec_op_t alu_ops[7] = '{ADD, SUB, AND, OR, XOR, SLT, SLTU};
    exec_op_t shift_ops[3] = '{SLL, SRL, SRA};

    jfive_exec_unit UUT (
        .reset        (reset),
        .clk          (clk),
        .cke          (cke),
        .s_valid      (s_valid),
        .s_op         (s_op),
        .s_rd_idx     (s_rd_idx),
        .s_rs1_val    (s_rs1_val),
        .s_rs2_val    (s_rs2_val),
        .s_imm_en     (s_imm_en),
        .s_imm_val    (s_imm_val),
        .m_valid      (m_valid),
        .m_rd_idx     (m_rd_idx),
        .m_rd_val     (m_rd_val),
        .m_acceptable (m_acceptable)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // reference model with the RV32I meaning of each operation
    // ----------------------------------------------------------------------

    function automatic logic [XLEN-1:0] model_result(input exec_op_t op,
                                                     input logic [XLEN-1:0] a,
                                                     input logic [XLEN-1:0] b);
        logic [SHAMT_BITS-1:0] sh;
        logic [XLEN-1:0]       r;
        sh = b[SHAMT_BITS-1:0];
        case (op)
            ADD:     r = a + b;
            SUB:     r = a - b;
            AND:     r = a & b;
            OR:      r = a | b;
            XOR:     r = a ^ b;
            SLT:     r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:    r = (a < b) ? 32'd1 : 32'd0;
            SLL:     r = a << sh;
            SRL:     r = a >> sh;
            SRA:     r = $signed(a) >>> sh;
            default: r = 'x;
        endcase
        return r;
    endfunction

    // ----------------------------------------------------------------------
    // checking
    // ----------------------------------------------------------------------

    always @(posedge clk) begin
        edges_seen++;
        if (!reset && cke && m_acceptable) begin
            if (m_valid && exp_val_q.size() == 0) begin
                data_errors++;
                $display("delivered index %0d with nothing outstanding", m_rd_idx);
            end else if (m_valid) begin
                front_val = exp_val_q.pop_front();
                front_idx = exp_idx_q.pop_front();
                front_stamp = exp_stamp_q.pop_front();
                front_name = exp_name_q.pop_front();
                checks++;
                assert (m_rd_idx === front_idx) else begin
                    data_errors++;
                    $display("Error %s index: expected %0d, actual %0d",
                             front_name, front_idx, m_rd_idx);
                end
                assert (m_rd_val === front_val) else begin
                    data_errors++;
                    $display("Error %s value: expected %h, actual %h",
                             front_name, front_val, m_rd_val);
                end
                assert (adv_count == front_stamp + 2) else begin
                    data_errors++;
                    $display("%s item came out after %0d advances instead of two",
                             front_name, adv_count - front_stamp);
                end
            end
            if (s_valid) begin
                b_val = s_imm_en ? s_imm_val : s_rs2_val;
                exp_val_q.push_back(model_result(s_op, s_rs1_val, b_val));
                exp_idx_q.push_back(s_rd_idx);
                exp_stamp_q.push_back(adv_count);
                exp_name_q.push_back(item_name);
                taken_cnt++;
            end
            adv_count++;
        end
    end

    // nothing in flight yet, so m_valid has to stay low
    always @(negedge clk) begin
        if (edges_seen > 0 && (reset || taken_cnt == 0)) begin
            assert (m_valid === 1'b0) else begin
                reset_errors++;
                $display("Error reset: expected m_valid 0, actual %b", m_valid);
            end
        end
    end

    stall_hold: assert property (
        @(posedge clk) disable iff (reset)
        $past(m_valid && !(cke && m_acceptable)) |->
            (m_valid && m_rd_idx == $past(m_rd_idx) && m_rd_val == $past(m_rd_val))
    ) else begin
        hold_errors++;
        $display("output item changed or vanished while the pipeline was stalled");
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------

    function automatic logic [XLEN-1:0] pick_operand();
        int unsigned sel;
        sel = $unsigned($random(seed)) % 8;
        case (sel)
            0:       return 32'h8000_0000;
            1:       return 32'h7fff_ffff;
            2:       return 32'hffff_ffff;
            3:       return 32'h0000_0000;
            default: return $random(seed);
        endcase
    endfunction

    // 12-bit signed immediate
    function automatic logic [XLEN-1:0] pick_imm();
        logic [11:0] raw;
        raw = 12'($random(seed));
        return {{(XLEN-12){raw[11]}}, raw};
    endfunction

    // one clock with flow control redrawn 1 ns after the edge
    task automatic tick(output logic adv);
        @(posedge clk);
        adv = cke && m_acceptable;
        #1;
        if (flow_random) begin
            cke = ($unsigned($random(seed)) % 100) >= cke_low_pct;
            m_acceptable = ($unsigned($random(seed)) % 100) >= bp_pct;
        end
    endtask

    task automatic idle_cycles(input int n);
        logic adv;
        repeat (n) tick(adv);
    endtask

    task automatic send_item(input string name, input exec_op_t op,
                             input logic [XLEN-1:0] rs1, input logic [XLEN-1:0] rs2,
                             input logic imm_en, input logic [XLEN-1:0] imm);
        logic adv;
        item_name = name;
        s_valid = 1'b1;
        s_op = op;
        s_rd_idx = RIDX_BITS'($random(seed));
        s_rs1_val = rs1;
        s_rs2_val = rs2;
        s_imm_en = imm_en;
        s_imm_val = imm;
        adv = 1'b0;
        while (!adv) tick(adv);
        s_valid = 1'b0;
    endtask

    task automatic alu_item(input string name, input logic imm_en);
        exec_op_t op;
        op = alu_ops[$unsigned($random(seed)) % 7];
        send_item(name, op, pick_operand(), pick_operand(), imm_en, pick_imm());
    endtask

    task automatic shift_item(input string name, input logic imm_en);
        exec_op_t op;
        op = shift_ops[$unsigned($random(seed)) % 3];
        send_item(name, op, pick_operand(), $random(seed), imm_en, pick_imm());
    endtask

    task automatic mixed_item(input string name);
        exec_op_t op;
        op = exec_op_t'(4'($unsigned($random(seed)) % 10));
        send_item(name, op, pick_operand(), pick_operand(), 1'($random(seed)), pick_imm());
    endtask

    initial begin
        reset = 1'b1;
        cke = 1'b1;
        m_acceptable = 1'b1;
        // a valid item offered during reset must not enter the pipeline
        s_valid = 1'b1;
        s_op = ADD;
        s_rd_idx = '0;
        s_rs1_val = '0;
        s_rs2_val = '0;
        s_imm_en = 1'b0;
        s_imm_val = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        s_valid = 1'b0;
        idle_cycles(3);

        repeat (N_ALU / 2) alu_item("alu_reg", 1'b0);
        repeat (N_ALU / 2) alu_item("alu_imm", 1'b1);
        // signed and unsigned compares across the sign bit
        send_item("slt_sign", SLT, 32'h8000_0000, 32'd1, 1'b0, '0);
        send_item("sltu_sign", SLTU, 32'h8000_0000, 32'd1, 1'b0, '0);
        send_item("slt_imm", SLT, 32'd0, '0, 1'b1, 32'hffff_ffff);
        send_item("sltu_imm", SLTU, 32'd0, '0, 1'b1, 32'hffff_ffff);

        repeat (N_SHIFT / 2) shift_item("shift_reg", 1'b0);
        repeat (N_SHIFT / 2) shift_item("shift_imm", 1'b1);
        send_item("sll_zero", SLL, 32'h1234_5678, 32'd0, 1'b0, '0);
        send_item("srl_max", SRL, 32'hf000_0001, 32'd31, 1'b0, '0);
        send_item("sra_max", SRA, 32'h8000_0000, '0, 1'b1, 32'd31);
        send_item("sra_zero", SRA, 32'hc000_0003, '0, 1'b1, 32'd0);
        send_item("sll_max", SLL, 32'h0000_0003, 32'hffff_ffff, 1'b0, '0);

        flow_random = 1'b1;
        bp_pct = 40;
        repeat (N_FLOW / 2) mixed_item("backpressure");
        cke_low_pct = 30;
        repeat (N_FLOW / 2) mixed_item("cke_random");

        // long holds with two items in flight
        flow_random = 1'b0;
        cke = 1'b1;
        m_acceptable = 1'b1;
        send_item("cke_hold", ADD, pick_operand(), pick_operand(), 1'b0, '0);
        send_item("cke_hold", SRA, 32'h8000_0010, 32'd4, 1'b0, '0);
        cke = 1'b0;
        idle_cycles(6);
        cke = 1'b1;
        idle_cycles(4);
        send_item("sink_hold", XOR, pick_operand(), pick_operand(), 1'b1, pick_imm());
        send_item("sink_hold", SLL, 32'h0000_0001, '0, 1'b1, 32'd31);
        m_acceptable = 1'b0;
        idle_cycles(6);
        m_acceptable = 1'b1;
        idle_cycles(6);

        assert (exp_val_q.size() == 0) else begin
            leftover_errors = exp_val_q.size();
            $display("%0d accepted items never came out", exp_val_q.size());
        end
        total_errors = data_errors + hold_errors + reset_errors + leftover_errors;
        $display("checks %0d, data errors %0d, stall errors %0d, reset errors %0d, lost %0d",
                 checks, data_errors, hold_errors, reset_errors, leftover_errors);
        if (total_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
